//--- logic/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

`define EX_XLEN       32          // datapath width
`define EX_RADDR_W    5           // register file address
`define EX_CNT_W      64          // retire counter
`define EX_DIV_STEPS  `EX_XLEN    // one quotient bit per step

`endif

//--- logic/exe_pkg.sv
package exe_pkg;

    // memory ops go through op_add for the address
    typedef enum logic [4:0] {
        op_add, op_sub, op_slt, op_sltu,
        op_and, op_or, op_nor, op_xor,
        op_sll, op_srl, op_sra, op_lui,
        op_mul_w, op_mulh_w, op_mulh_wu,
        op_div_w, op_mod_w, op_div_wu, op_mod_wu,
        op_rdcntvl, op_rdcntvh
    } exe_op_e;

    typedef enum logic [3:0] {
        mem_none,
        ld_b, ld_bu, ld_h, ld_hu, ld_w,
        st_b, st_h, st_w
    } mem_op_e;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_e;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module alu import exe_pkg::*; (
    input  exe_op_e             op,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] src2,
    output logic [`EX_XLEN-1:0] result
);

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = src2[SHAMT_W-1:0];    // only low bits count
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            op_add:  result = src1 + src2;
            op_sub:  result = src1 - src2;
            op_slt:  result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            op_sltu: result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_nor:  result = ~(src1 | src2);
            op_xor:  result = src1 ^ src2;
            op_sll:  result = src1 << shamt;
            op_srl:  result = src1 >> shamt;
            op_sra:  result = $unsigned($signed(src1) >>> shamt);
            op_lui:  result = src2;          // immediate already shifted by decode
            default: result = '0;            // mul/div/rdcnt handled elsewhere
        endcase
    end

endmodule

//--- logic/radix2_divider.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module radix2_divider import exe_pkg::*; #(
    parameter int WIDTH = `EX_XLEN
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             start,
    input  logic             div_signed,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic             ready,
    output logic             done,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);

    localparam int CNT_W = $clog2(`EX_DIV_STEPS);

    div_state_e       state;
    logic [CNT_W-1:0] step_cnt;
    logic [WIDTH-1:0] quo_q;
    logic [WIDTH-1:0] rem_q;
    logic [WIDTH-1:0] dsr_q;
    logic             neg_quo;
    logic             neg_rem;
    logic             by_zero;
    logic [WIDTH-1:0] abs_dvd;
    logic [WIDTH-1:0] abs_dsr;
    logic [WIDTH:0]   rem_shift;
    logic [WIDTH+1:0] diff;

    assign abs_dvd = (div_signed && dividend[WIDTH-1]) ? -dividend : dividend;
    assign abs_dsr = (div_signed && divisor[WIDTH-1]) ? -divisor : divisor;

    // shift in next dividend bit, then trial subtract
    assign rem_shift = {rem_q, quo_q[WIDTH-1]};
    assign diff      = {1'b0, rem_shift} - {2'b00, dsr_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= div_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state    <= div_run;
                        step_cnt <= '0;
                    end
                end
                div_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(`EX_DIV_STEPS - 1)) state <= div_done;
                end
                default: state <= div_idle;  // div_done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle && start) begin
            quo_q   <= abs_dvd;
            rem_q   <= '0;
            dsr_q   <= abs_dsr;
            neg_quo <= div_signed & (dividend[WIDTH-1] ^ divisor[WIDTH-1]);
            neg_rem <= div_signed & dividend[WIDTH-1];
            by_zero <= (divisor == '0);
        end else if (state == div_run) begin
            if (!diff[WIDTH+1]) begin
                rem_q <= diff[WIDTH-1:0];
                quo_q <= {quo_q[WIDTH-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[WIDTH-1:0];
                quo_q <= {quo_q[WIDTH-2:0], 1'b0};
            end
        end
    end

    assign ready = (state == div_idle);
    assign done  = (state == div_done);

    // remainder already equals the dividend when divisor is zero
    assign quotient  = by_zero ? '1 : (neg_quo ? -quo_q : quo_q);
    assign remainder = neg_rem ? -rem_q : rem_q;

endmodule

//--- logic/mem_access_gen.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module mem_access_gen import exe_pkg::*; (
    input  logic                   valid,
    input  mem_op_e                mem_op,
    input  logic [`EX_XLEN-1:0]    addr,
    input  logic [`EX_XLEN-1:0]    rkd_value,
    output logic                   data_sram_en,
    output logic [`EX_XLEN/8-1:0]  data_sram_we,
    output logic [`EX_XLEN-1:0]    data_sram_addr,
    output logic [`EX_XLEN-1:0]    data_sram_wdata,
    output logic                   es_ale
);

    localparam int STRB_W = `EX_XLEN / 8;

    logic              is_load;
    logic              is_store;
    logic              misalign;
    logic [STRB_W-1:0] strobe;

    assign is_load  = mem_op inside {ld_b, ld_bu, ld_h, ld_hu, ld_w};
    assign is_store = mem_op inside {st_b, st_h, st_w};
    assign misalign = (mem_op inside {ld_h, ld_hu, st_h}) & addr[0]
                    | (mem_op inside {ld_w, st_w}) & (|addr[1:0]);

    always_comb begin
        case (mem_op)
            st_b: begin
                strobe          = STRB_W'(1) << addr[1:0];
                data_sram_wdata = {4{rkd_value[7:0]}};
            end
            st_h: begin
                strobe          = STRB_W'(3) << {addr[1], 1'b0};
                data_sram_wdata = {2{rkd_value[15:0]}};
            end
            default: begin
                strobe          = {STRB_W{mem_op == st_w}};  // zero for loads
                data_sram_wdata = rkd_value;
            end
        endcase
    end

    assign es_ale         = valid & misalign;
    assign data_sram_en   = valid & (is_load | is_store) & ~misalign;
    assign data_sram_we   = strobe & {STRB_W{valid & ~misalign}};
    assign data_sram_addr = {addr[`EX_XLEN-1:2], 2'b00};   // word aligned

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module ex_stage import exe_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     ds_to_es_valid,
    input  exe_op_e                  op,
    input  mem_op_e                  mem_op,
    input  logic [`EX_XLEN-1:0]      src1,
    input  logic [`EX_XLEN-1:0]      src2,
    input  logic [`EX_XLEN-1:0]      rkd_value,
    input  logic                     rf_we,
    input  logic [`EX_RADDR_W-1:0]   rf_waddr,
    input  logic [`EX_XLEN-1:0]      pc,
    input  logic                     ms_allowin,
    output logic                     es_valid_q,
    output mem_op_e                  mem_op_q,
    output logic [`EX_XLEN-1:0]      alu_result,
    output logic [`EX_XLEN-1:0]      rkd_value_q,
    output logic                     div_start,
    output logic                     div_signed,
    output logic [`EX_XLEN-1:0]      dividend,
    output logic [`EX_XLEN-1:0]      divisor,
    input  logic                     div_ready,
    input  logic                     div_done,
    input  logic [`EX_XLEN-1:0]      quotient,
    input  logic [`EX_XLEN-1:0]      remainder,
    output logic                     es_allowin,
    output logic                     es_to_ms_valid,
    output logic [`EX_XLEN-1:0]      es_result,
    output logic                     es_rf_we,
    output logic [`EX_RADDR_W-1:0]   es_rf_waddr,
    output logic [`EX_XLEN-1:0]      es_pc,
    output logic                     es_res_from_mem
);

    exe_op_e                     op_q;
    logic [`EX_XLEN-1:0]         src1_q;
    logic [`EX_XLEN-1:0]         src2_q;
    logic                        rf_we_q;
    logic [`EX_RADDR_W-1:0]      rf_waddr_q;
    logic [`EX_XLEN-1:0]         pc_q;
    logic                        is_div;
    logic                        ready_go;
    logic                        leave;
    logic                        div_issued;
    logic                        div_done_flag;
    logic [`EX_CNT_W-1:0]        retire_cnt;
    logic signed [2*`EX_XLEN-1:0] prod_s;
    logic [2*`EX_XLEN-1:0]       prod_u;

    assign is_div         = op_q inside {op_div_w, op_mod_w, op_div_wu, op_mod_wu};
    assign ready_go       = ~is_div | div_done_flag;
    assign es_allowin     = ~es_valid_q | (ready_go & ms_allowin);
    assign es_to_ms_valid = es_valid_q & ready_go;
    assign leave          = es_to_ms_valid & ms_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) es_valid_q <= 1'b0;
        else if (es_allowin) es_valid_q <= ds_to_es_valid;
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            op_q        <= op;
            mem_op_q    <= mem_op;
            src1_q      <= src1;
            src2_q      <= src2;
            rkd_value_q <= rkd_value;
            rf_we_q     <= rf_we;
            rf_waddr_q  <= rf_waddr;
            pc_q        <= pc;
        end
    end

    // one request per instruction, result kept until it leaves
    always_ff @(posedge clk) begin
        if (!resetn || leave) begin
            div_issued    <= 1'b0;
            div_done_flag <= 1'b0;
        end else begin
            if (div_start && div_ready) div_issued <= 1'b1;
            if (div_done) div_done_flag <= 1'b1;
        end
    end

    assign div_start  = es_valid_q & is_div & ~div_issued;
    assign div_signed = op_q inside {op_div_w, op_mod_w};
    assign dividend   = src1_q;
    assign divisor    = src2_q;

    always_ff @(posedge clk) begin
        if (!resetn) retire_cnt <= '0;
        else if (leave) retire_cnt <= retire_cnt + 1'b1;
    end

    alu u_alu (
        .op     (op_q),
        .src1   (src1_q),
        .src2   (src2_q),
        .result (alu_result)
    );

    assign prod_s = $signed(src1_q) * $signed(src2_q);
    assign prod_u = src1_q * src2_q;

    always_comb begin
        case (op_q)
            op_mul_w:             es_result = prod_s[`EX_XLEN-1:0];
            op_mulh_w:            es_result = prod_s[2*`EX_XLEN-1:`EX_XLEN];
            op_mulh_wu:           es_result = prod_u[2*`EX_XLEN-1:`EX_XLEN];
            op_div_w, op_div_wu:  es_result = quotient;
            op_mod_w, op_mod_wu:  es_result = remainder;
            op_rdcntvl:           es_result = retire_cnt[`EX_XLEN-1:0];
            op_rdcntvh:           es_result = retire_cnt[`EX_CNT_W-1:`EX_XLEN];
            default:              es_result = alu_result;
        endcase
    end

    assign es_rf_we        = es_valid_q & rf_we_q;
    assign es_rf_waddr     = rf_waddr_q;
    assign es_pc           = pc_q;
    assign es_res_from_mem = es_valid_q & (mem_op_q inside {ld_b, ld_bu, ld_h, ld_hu, ld_w});

endmodule

//--- logic/exe_top.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_top import exe_pkg::*; (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     ds_to_es_valid,
    input  exe_op_e                  op,
    input  mem_op_e                  mem_op,
    input  logic [`EX_XLEN-1:0]      src1,
    input  logic [`EX_XLEN-1:0]      src2,
    input  logic [`EX_XLEN-1:0]      rkd_value,
    input  logic                     rf_we,
    input  logic [`EX_RADDR_W-1:0]   rf_waddr,
    input  logic [`EX_XLEN-1:0]      pc,
    input  logic                     ms_allowin,
    output logic                     es_allowin,
    output logic                     es_to_ms_valid,
    output logic [`EX_XLEN-1:0]      es_result,
    output logic                     es_rf_we,
    output logic [`EX_RADDR_W-1:0]   es_rf_waddr,
    output logic [`EX_XLEN-1:0]      es_pc,
    output logic                     es_res_from_mem,
    output logic                     es_ale,
    output logic                     data_sram_en,
    output logic [`EX_XLEN/8-1:0]    data_sram_we,
    output logic [`EX_XLEN-1:0]      data_sram_addr,
    output logic [`EX_XLEN-1:0]      data_sram_wdata
);

    logic                es_valid_q;
    mem_op_e             mem_op_q;
    logic [`EX_XLEN-1:0] alu_result;
    logic [`EX_XLEN-1:0] rkd_value_q;
    logic                div_start;
    logic                div_signed;
    logic [`EX_XLEN-1:0] dividend;
    logic [`EX_XLEN-1:0] divisor;
    logic                div_ready;
    logic                div_done;
    logic [`EX_XLEN-1:0] quotient;
    logic [`EX_XLEN-1:0] remainder;

    ex_stage u_ex_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ds_to_es_valid  (ds_to_es_valid),
        .op              (op),
        .mem_op          (mem_op),
        .src1            (src1),
        .src2            (src2),
        .rkd_value       (rkd_value),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .pc              (pc),
        .ms_allowin      (ms_allowin),
        .es_valid_q      (es_valid_q),
        .mem_op_q        (mem_op_q),
        .alu_result      (alu_result),
        .rkd_value_q     (rkd_value_q),
        .div_start       (div_start),
        .div_signed      (div_signed),
        .dividend        (dividend),
        .divisor         (divisor),
        .div_ready       (div_ready),
        .div_done        (div_done),
        .quotient        (quotient),
        .remainder       (remainder),
        .es_allowin      (es_allowin),
        .es_to_ms_valid  (es_to_ms_valid),
        .es_result       (es_result),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_pc           (es_pc),
        .es_res_from_mem (es_res_from_mem)
    );

    radix2_divider #(
        .WIDTH (`EX_XLEN)
    ) u_divider (
        .clk        (clk),
        .resetn     (resetn),
        .start      (div_start),
        .div_signed (div_signed),
        .dividend   (dividend),
        .divisor    (divisor),
        .ready      (div_ready),
        .done       (div_done),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    // address comes straight from the alu adder
    mem_access_gen u_mem_access_gen (
        .valid           (es_valid_q),
        .mem_op          (mem_op_q),
        .addr            (alu_result),
        .rkd_value       (rkd_value_q),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .es_ale          (es_ale)
    );

endmodule

//--- verification/exe_checker.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_checker import exe_pkg::*; (
    input logic                    clk,
    input logic                    resetn,
    input logic                    es_to_ms_valid,
    input logic                    ms_allowin,
    input logic [`EX_XLEN-1:0]     es_result,
    input logic                    es_rf_we,
    input logic [`EX_RADDR_W-1:0]  es_rf_waddr,
    input logic [`EX_XLEN-1:0]     es_pc,
    input logic                    es_res_from_mem,
    input logic                    es_ale,
    input logic                    data_sram_en,
    input logic [`EX_XLEN/8-1:0]   data_sram_we,
    input logic [`EX_XLEN-1:0]     data_sram_addr,
    input logic [`EX_XLEN-1:0]     data_sram_wdata
);

    typedef struct packed {
        logic [15:0]            id;
        exe_op_e                op;
        mem_op_e                mem_op;
        logic [`EX_XLEN-1:0]    result;
        logic [`EX_XLEN/8-1:0]  strb;
        logic [`EX_XLEN-1:0]    wdata;
        logic                   ale;
        logic [`EX_RADDR_W-1:0] waddr;
        logic [`EX_XLEN-1:0]    pc;
    } expect_t;

    expect_t exp_q[$];    // program order
    int      error_count   = 0;
    int      retired_count = 0;

    task automatic push_expect(input expect_t e);
        exp_q.push_back(e);
    endtask

    task automatic compare(input string test, input string field,
                           input logic [`EX_XLEN-1:0] exp, input logic [`EX_XLEN-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test, field, exp, act);
            error_count++;
        end
    endtask

    task automatic check_retire(input expect_t e);
        string name;
        logic  is_load;
        logic  is_store;
        name     = $sformatf("test %0d %s/%s", e.id, e.op.name(), e.mem_op.name());
        is_load  = e.mem_op inside {ld_b, ld_bu, ld_h, ld_hu, ld_w};
        is_store = e.mem_op inside {st_b, st_h, st_w};
        compare(name, "pc", e.pc, es_pc);
        compare(name, "result", e.result, es_result);
        compare(name, "rf_waddr", 32'(e.waddr), 32'(es_rf_waddr));
        compare(name, "rf_we", 32'(!is_store), 32'(es_rf_we));
        compare(name, "res_from_mem", 32'(is_load), 32'(es_res_from_mem));
        compare(name, "ale", 32'(e.ale), 32'(es_ale));
        compare(name, "sram_en", 32'((is_load | is_store) & !e.ale), 32'(data_sram_en));
        compare(name, "sram_we", 32'(e.strb), 32'(data_sram_we));
        if (is_load || is_store) compare(name, "sram_addr", {e.result[`EX_XLEN-1:2], 2'b00},
                                         data_sram_addr);
        if (e.strb != '0) compare(name, "sram_wdata", e.wdata, data_sram_wdata);
    endtask

    // one check per instruction leaving the stage
    always @(posedge clk) begin
        if (resetn && es_to_ms_valid && ms_allowin) begin
            if (exp_q.size() == 0) begin
                $display("instruction at pc %h retired with nothing left to expect", es_pc);
                error_count++;
            end else begin
                check_retire(exp_q.pop_front());
            end
            retired_count++;
        end
    end

endmodule

//--- verification/exe_sva.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_sva (
    input logic                   clk,
    input logic                   resetn,
    input logic                   es_to_ms_valid,
    input logic                   ms_allowin,
    input logic [`EX_XLEN-1:0]    es_result,
    input logic [`EX_XLEN-1:0]    es_pc,
    input logic [`EX_RADDR_W-1:0] es_rf_waddr,
    input logic                   div_start
);

    logic div_seen;    // div_start already raised for this instruction

    always_ff @(posedge clk) begin
        if (!resetn || (es_to_ms_valid && ms_allowin)) div_seen <= 1'b0;
        else if (div_start) div_seen <= 1'b1;
    end

    held_while_stalled: assert property (@(posedge clk) disable iff (!resetn)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && $stable(es_result)
                                          && $stable(es_pc) && $stable(es_rf_waddr))
        else $error("stage outputs changed while ms_allowin was low");

    single_div_request: assert property (@(posedge clk) disable iff (!resetn)
        $rose(div_start) |-> !div_seen)
        else $error("div_start raised again for the same instruction");

    quiet_in_reset: assert property (@(posedge clk) !resetn |=> !es_to_ms_valid)
        else $error("es_to_ms_valid high during reset");

endmodule

bind ex_stage exe_sva i_sva (
    .clk            (clk),
    .resetn         (resetn),
    .es_to_ms_valid (es_to_ms_valid),
    .ms_allowin     (ms_allowin),
    .es_result      (es_result),
    .es_pc          (es_pc),
    .es_rf_waddr    (es_rf_waddr),
    .div_start      (div_start)
);

//--- verification/exe_tb.sv
`timescale 1ns/1ps
`include "exe_defines.svh"

module exe_tb import exe_pkg::*;;

    localparam logic [31:0]         SEED    = 32'h1d32a82c;
    localparam logic [`EX_XLEN-1:0] PC_BASE = 32'h1c00_0000;

    typedef struct packed {
        exe_op_e                op;
        mem_op_e                mem_op;
        logic [`EX_XLEN-1:0]    src1;
        logic [`EX_XLEN-1:0]    src2;
        logic [`EX_XLEN-1:0]    rkd;
        logic [`EX_RADDR_W-1:0] waddr;
        logic [`EX_XLEN-1:0]    result;
        logic [`EX_XLEN/8-1:0]  strb;
        logic [`EX_XLEN-1:0]    wdata;
        logic                   ale;
    } vector_t;

    logic                    clk;
    logic                    resetn;
    logic                    ds_to_es_valid;
    exe_op_e                 op;
    mem_op_e                 mem_op;
    logic [`EX_XLEN-1:0]     src1;
    logic [`EX_XLEN-1:0]     src2;
    logic [`EX_XLEN-1:0]     rkd_value;
    logic                    rf_we;
    logic [`EX_RADDR_W-1:0]  rf_waddr;
    logic [`EX_XLEN-1:0]     pc;
    logic                    ms_allowin;
    logic                    es_allowin;
    logic                    es_to_ms_valid;
    logic [`EX_XLEN-1:0]     es_result;
    logic                    es_rf_we;
    logic [`EX_RADDR_W-1:0]  es_rf_waddr;
    logic [`EX_XLEN-1:0]     es_pc;
    logic                    es_res_from_mem;
    logic                    es_ale;
    logic                    data_sram_en;
    logic [`EX_XLEN/8-1:0]   data_sram_we;
    logic [`EX_XLEN-1:0]     data_sram_addr;
    logic [`EX_XLEN-1:0]     data_sram_wdata;

    vector_t     lines[$];
    int          tb_errors = 0;
    logic        loaded    = 1'b0;
    logic [31:0] bp_rng    = SEED;
    logic [31:0] gap_rng   = SEED;

    exe_top i_dut (.*);

    exe_checker i_checker (
        .clk             (clk),
        .resetn          (resetn),
        .es_to_ms_valid  (es_to_ms_valid),
        .ms_allowin      (ms_allowin),
        .es_result       (es_result),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_pc           (es_pc),
        .es_res_from_mem (es_res_from_mem),
        .es_ale          (es_ale),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic exe_op_e op_from_name(input string s);
        exe_op_e e;
        e = e.first();
        for (int k = 0; k < e.num(); k++) begin
            if (e.name() == s) return e;
            e = e.next();
        end
        return e;
    endfunction

    function automatic mem_op_e mem_from_name(input string s);
        mem_op_e e;
        e = e.first();
        for (int k = 0; k < e.num(); k++) begin
            if (e.name() == s) return e;
            e = e.next();
        end
        return e;
    endfunction

    task automatic load_vectors();
        int                  fd;
        int                  got;
        string               text;
        string               op_s;
        string               mem_s;
        logic [`EX_XLEN-1:0] f_src1, f_src2, f_rkd, f_waddr, f_res, f_strb, f_wdata, f_ale;
        vector_t             v;
        fd = $fopen("verification/exe_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/exe_input.txt");
            tb_errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.getc(0) == "#") continue;  // comments, blank lines
            got = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h", op_s, mem_s, f_src1, f_src2,
                          f_rkd, f_waddr, f_res, f_strb, f_wdata, f_ale);
            v.op     = op_from_name(op_s);
            v.mem_op = mem_from_name(mem_s);
            if (got != 10 || v.op.name() != op_s || v.mem_op.name() != mem_s) begin
                $display("malformed line in data file: %s", text);
                tb_errors++;
                continue;
            end
            v.src1   = f_src1;
            v.src2   = f_src2;
            v.rkd    = f_rkd;
            v.waddr  = f_waddr[`EX_RADDR_W-1:0];
            v.result = f_res;
            v.strb   = f_strb[`EX_XLEN/8-1:0];
            v.wdata  = f_wdata;
            v.ale    = f_ale[0];
            lines.push_back(v);
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            $display("data file holds no instructions");
            tb_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory stage stalls on about a quarter of cycles
    always @(posedge clk) begin
        if (!resetn) begin
            ms_allowin <= 1'b0;
        end else begin
            bp_rng = xorshift32(bp_rng);
            ms_allowin <= (bp_rng[1:0] != 2'b00);
        end
    end

    initial begin
        wait (loaded);
        repeat (lines.size() * (`EX_DIV_STEPS + 10) * 4) @(posedge clk);
        $display("timeout: %0d of %0d instructions retired", i_checker.retired_count,
                 lines.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        vector_t             v;
        logic [`EX_XLEN-1:0] next_pc;
        int                  total;
        resetn         = 1'b0;
        ds_to_es_valid = 1'b0;
        op             = op_add;
        mem_op         = mem_none;
        src1           = '0;
        src2           = '0;
        rkd_value      = '0;
        rf_we          = 1'b0;
        rf_waddr       = '0;
        pc             = '0;
        ms_allowin     = 1'b0;
        load_vectors();
        if (lines.size() > 0) loaded = 1'b1;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < lines.size(); i++) begin
            v       = lines[i];
            next_pc = PC_BASE + 32'(i * 4);
            gap_rng = xorshift32(gap_rng);
            if (gap_rng[2:0] < 3'd2) begin    // idle bubble from decode
                ds_to_es_valid <= 1'b0;
                @(posedge clk);
            end
            ds_to_es_valid <= 1'b1;
            op             <= v.op;
            mem_op         <= v.mem_op;
            src1           <= v.src1;
            src2           <= v.src2;
            rkd_value      <= v.rkd;
            rf_we          <= !(v.mem_op inside {st_b, st_h, st_w});
            rf_waddr       <= v.waddr;
            pc             <= next_pc;
            i_checker.push_expect({16'(i), v.op, v.mem_op, v.result, v.strb, v.wdata, v.ale,
                                   v.waddr, next_pc});
            @(posedge clk);
            while (!es_allowin) @(posedge clk);
        end
        ds_to_es_valid <= 1'b0;
        while (i_checker.retired_count < lines.size()) @(posedge clk);
        repeat (4) @(posedge clk);
        if (i_checker.retired_count != lines.size()) begin
            $display("%0d instructions retired but only %0d were issued",
                     i_checker.retired_count, lines.size());
            tb_errors++;
        end
        total = i_checker.error_count + tb_errors;
        $display("errors: %0d in checker, %0d in testbench", i_checker.error_count, tb_errors);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- exe_top.f
+incdir+logic
logic/exe_pkg.sv
logic/alu.sv
logic/radix2_divider.sv
logic/mem_access_gen.sv
logic/ex_stage.sv
logic/exe_top.sv
verification/exe_checker.sv
verification/exe_sva.sv
verification/exe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds exe_tb with verilator, runs it and scans sim.log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module exe_tb \
    -f exe_top.f -o exe_sim > build.log 2>&1 \
    && ./obj_dir/exe_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

//--- verification/exe_input.txt
# columns: op mem_op src1 src2 rkd_value rf_waddr, then expected result strobe wdata ale
# all hex; loads and stores use op_add and expect the effective address as result
op_add     mem_none 00000005 00000007 00000000 01 0000000c 0 00000000 0
op_sub     mem_none 00000003 00000005 00000000 02 fffffffe 0 00000000 0
op_slt     mem_none ffffffff 00000001 00000000 03 00000001 0 00000000 0
op_sltu    mem_none ffffffff 00000001 00000000 04 00000000 0 00000000 0
op_nor     mem_none 0f0f0000 00ff00f0 00000000 05 f000ff0f 0 00000000 0
op_xor     mem_none a5a5a5a5 ffff0000 00000000 06 5a5aa5a5 0 00000000 0
op_sra     mem_none 80000000 00000024 00000000 07 f8000000 0 00000000 0
op_sll     mem_none 00000003 0000001f 00000000 08 80000000 0 00000000 0
op_lui     mem_none 00000000 12345000 00000000 09 12345000 0 00000000 0
op_rdcntvl mem_none 00000000 00000000 00000000 0a 00000009 0 00000000 0
op_mul_w   mem_none fffffffd 00000007 00000000 0b ffffffeb 0 00000000 0
op_mulh_w  mem_none fffffffd 00000007 00000000 0c ffffffff 0 00000000 0
op_mulh_wu mem_none fffffffd 00000007 00000000 0d 00000006 0 00000000 0
op_div_w   mem_none fffffff9 00000002 00000000 0e fffffffd 0 00000000 0
op_and     mem_none 0000ff0f 00000ff0 00000000 0f 00000f00 0 00000000 0
op_mod_w   mem_none fffffff9 00000002 00000000 10 ffffffff 0 00000000 0
op_div_wu  mem_none 00000064 00000000 00000000 11 ffffffff 0 00000000 0
op_mod_wu  mem_none 00000064 00000000 00000000 12 00000064 0 00000000 0
op_div_wu  mem_none 80000000 00000003 00000000 13 2aaaaaaa 0 00000000 0
op_mod_w   mem_none 00000007 fffffffe 00000000 14 00000001 0 00000000 0
op_or      mem_none 12340000 00005678 00000000 15 12345678 0 00000000 0
op_add     st_b     00001000 00000003 000000ab 16 00001003 8 abababab 0
op_add     st_b     00001000 00000000 00000012 17 00001000 1 12121212 0
op_add     st_h     00002000 00000002 0000beef 18 00002002 c beefbeef 0
op_add     st_w     00003000 00000004 12345678 19 00003004 f 12345678 0
op_add     ld_w     00004000 00000008 00000000 1a 00004008 0 00000000 0
op_add     ld_h     00004000 00000001 00000000 1b 00004001 0 00000000 1
op_add     st_w     00005000 00000002 11111111 1c 00005002 0 00000000 1
op_rdcntvl mem_none 00000000 00000000 00000000 1d 0000001c 0 00000000 0
op_rdcntvh mem_none 00000000 00000000 00000000 1e 00000000 0 00000000 0
